/* sources.f */
verilog/regfile_pkg.sv
verilog/regfile_ram.sv
verilog/regfile_live_select.sv
verilog/regfile_2w2r.sv
tests/regfile_live_select_sva.sv
tests/tb_regfile_2w2r.sv

/* tests/tb_regfile_2w2r.sv */
`timescale 1ns/1ps

module tb_regfile_2w2r;

   // ==============================
   // Run length
   // ==============================

   localparam int DEP     = regfile_pkg::PREGS;
   localparam int NB      = regfile_pkg::NBYTE;
   localparam int AW      = regfile_pkg::AWID;
   localparam int RST_CYC = 5;                // Reset held this many cycles
   localparam int N_ZERO  = 16;               // Reads right after reset
   localparam int N_FULL  = 32;               // Full word writes followed by as many reads
   localparam int N_MERGE = 12;               // Partial writes to one register
   localparam int N_OVER  = 8;                // Same cycle collisions
   localparam int N_SAME  = 8;                // Read and write at one edge
   localparam int N_HOLD  = 10;               // Cycles with reads idle
   localparam int N_RAND  = 200;              // Mixed random traffic

   localparam int TOTAL_CYCLES = RST_CYC + N_ZERO + 2 * N_FULL + 2 * N_MERGE
                               + 2 * N_OVER + 2 * N_SAME + N_HOLD + 1 + N_RAND + 3;
   localparam int WATCHDOG_NS  = 2 * TOTAL_CYCLES * 10;

   localparam logic [31:0] SEED = 32'h792a_945e;

   // ==============================
   // DUT and its ports
   // ==============================

   logic                  clka;
   logic                  rst_n;
   regfile_pkg::wr_port_t wr [2];
   regfile_pkg::rd_req_t  rd [2];
   regfile_pkg::entry_t   rd_data [2];

   regfile_pkg::entry_t   model [DEP];        // Reference contents
   regfile_pkg::entry_t   exp_q [2];          // Expected read data per port
   logic [31:0]           lfsr;
   int                    n_errors;           // Data mismatches
   int                    n_reads;            // Enabled reads seen by the model

   regfile_2w2r #(
      .DEP     (DEP)
   ) DUT (
      .clka    (clka),
      .rst_n   (rst_n),
      .wr      (wr),
      .rd      (rd),
      .rd_data (rd_data)
   );

   // Table assertions ride along inside the live-value table
   bind regfile_live_select regfile_live_select_sva #(
      .DEP   (DEP)
   ) u_sva (
      .clka  (clka),
      .rst_n (rst_n),
      .rd    (rd),
      .wmask (wmask),
      .waddr (waddr),
      .own   (own),
      .sel_q (sel_q)
   );

   always #5 clka = ~clka;                    // 10 ns period

   // ==============================
   // Stimulus helpers
   // ==============================

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit taken
   task automatic draw(input int n, output logic [71:0] v);
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[70:0], lfsr[0]};
      end
   endtask

   task automatic clear_inputs();
      for (int p = 0; p < 2; p++) begin
         wr[p] = '0;
         rd[p] = '0;
      end
   endtask

   // Inputs change only on the falling edge
   task automatic next_cycle();
      @(negedge clka);
      clear_inputs();
   endtask

   task automatic set_write(input int p, input logic [AW-1:0] addr,
                            input logic [NB-1:0] be, input logic [71:0] data);
      wr[p].en   = 1'b1;
      wr[p].be   = be;
      wr[p].addr = addr;
      wr[p].data = data;
   endtask

   task automatic set_read(input int p, input logic [AW-1:0] addr);
      rd[p].en   = 1'b1;
      rd[p].addr = addr;
   endtask

   // Failures of the bound table assertions
   function automatic int table_errors();
      return DUT.u_lvt.u_sva.n_fail;
   endfunction

   task automatic print_counts();
      $display("reads %0d, data errors %0d, table errors %0d", n_reads, n_errors,
               table_errors());
   endtask

   // ==============================
   // Reference model
   // ==============================

   // Read before write at every edge
   // Port 1 applied last so it wins a shared lane
   always @(posedge clka or negedge rst_n) begin
      if (!rst_n) begin
         exp_q[0] <= '0;
         exp_q[1] <= '0;
      end else begin
         for (int p = 0; p < 2; p++) begin
            if (rd[p].en) begin
               exp_q[p] <= model[rd[p].addr];   // Old contents
               n_reads++;
            end
         end
         for (int w = 0; w < 2; w++) begin
            for (int b = 0; b < NB; b++) begin
               if (wr[w].en && wr[w].be[b]) begin
                  model[wr[w].addr][b*8 +: 8] <= wr[w].data[b*8 +: 8];
               end
            end
         end
      end
   end

   // Compared on every edge as both sides hold while en is low
   for (genvar i = 0; i < 2; i++) begin : g_chk
      a_rd_data : assert property (@(posedge clka) disable iff (!rst_n)
                                   rd_data[i] == exp_q[i])
      else begin
         n_errors++;
         $display("error at %0t ns rd_data[%0d] expected %h actual %h", $time, i,
                  $sampled(exp_q[i]), $sampled(rd_data[i]));
      end
   end

   // ==============================
   // Test sequence
   // ==============================

   initial begin
      logic [71:0] d0;
      logic [71:0] d1;
      logic [71:0] x;
      logic [71:0] y;
      logic [NB-1:0] be0;
      logic [NB-1:0] be1;

      clka     = 1'b0;
      rst_n    = 1'b0;
      lfsr     = SEED;
      n_errors = 0;
      n_reads  = 0;
      clear_inputs();
      for (int n = 0; n < DEP; n++) begin
         model[n] = '0;                       // RAM powers up cleared
      end
      repeat (RST_CYC) @(posedge clka);
      @(negedge clka);
      rst_n = 1'b1;

      // Fresh file reads as zero
      for (int k = 0; k < N_ZERO; k++) begin
         next_cycle();
         draw(AW, x);
         set_read(0, x[AW-1:0]);
         draw(AW, x);
         set_read(1, x[AW-1:0]);
      end

      // Full words with the first half on port 0 and the second half on port 1
      for (int k = 0; k < N_FULL; k++) begin
         next_cycle();
         draw(72, d0);
         set_write((k < N_FULL / 2) ? 0 : 1, k, '1, d0);
      end
      for (int k = 0; k < N_FULL; k++) begin
         next_cycle();
         set_read(0, k);
         set_read(1, N_FULL - 1 - k);
      end

      // Byte merge from alternating ports
      for (int k = 0; k < N_MERGE; k++) begin
         next_cycle();
         draw(72, d0);
         draw(NB, y);
         set_write(k % 2, 40, y[NB-1:0], d0);
         next_cycle();
         set_read(k % 2, 40);
      end

      // Collision with lane 4 always shared
      for (int k = 0; k < N_OVER; k++) begin
         next_cycle();
         draw(NB, y);
         be0 = y[NB-1:0] | 9'h010;
         draw(NB, y);
         be1 = y[NB-1:0] | 9'h010;
         draw(72, d0);
         draw(72, d1);
         set_write(0, 41, be0, d0);
         set_write(1, 41, be1, d1);
         next_cycle();
         set_read(0, 41);
         set_read(1, 41);
      end

      // Old entry at the write edge and the new one on the next read
      for (int k = 0; k < N_SAME; k++) begin
         next_cycle();
         draw(72, d0);
         set_write(k % 2, k, '1, d0);
         set_read(0, k);                      // Sees the phase two word
         next_cycle();
         set_read(1, k);                      // Sees the word just written
      end

      // Reads idle while the same registers keep changing
      next_cycle();
      set_read(0, 40);
      set_read(1, 41);
      for (int k = 0; k < N_HOLD; k++) begin
         next_cycle();
         draw(72, d0);
         set_write(k % 2, (k % 2) ? 41 : 40, '1, d0);
      end

      // Mixed traffic
      for (int k = 0; k < N_RAND; k++) begin
         next_cycle();
         for (int p = 0; p < 2; p++) begin
            draw(1, y);
            if (y[0]) begin
               draw(AW, x);
               draw(NB, y);
               draw(72, d0);
               set_write(p, x[AW-1:0], y[NB-1:0], d0);
            end
            draw(1, y);
            if (y[0]) begin
               draw(AW, x);
               set_read(p, x[AW-1:0]);
            end
         end
      end

      next_cycle();
      repeat (2) @(negedge clka);             // Last read reaches the checker

      print_counts();
      if (n_errors == 0 && table_errors() == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   // ==============================
   // Watchdog
   // ==============================

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired before the test sequence finished");
      print_counts();
      $display("TB FAILED");
      $finish;
   end

endmodule

/* tests/regfile_live_select_sva.sv */
`timescale 1ns/1ps

// Checks on the owner table and the registered owner bits
module regfile_live_select_sva #(
   parameter  int DEP  = regfile_pkg::PREGS,
   localparam int ABIT = (DEP > 1) ? $clog2(DEP) : 1,
   localparam int NB   = regfile_pkg::NBYTE
) (
   input logic                 clka,
   input logic                 rst_n,
   input regfile_pkg::rd_req_t rd [2],
   input logic [NB-1:0]        wmask [2],     // Lanes written this cycle
   input logic [ABIT-1:0]      waddr [2],
   input logic [NB-1:0]        own [DEP],     // Owner table
   input logic [NB-1:0]        sel_q [2]      // Owner bits held with the read
);

   int n_fail = 0;                            // Failed table checks

   // ==============================
   // Table contents
   // ==============================

   for (genvar r = 0; r < DEP; r++) begin : g_known
      a_own_known : assert property (@(posedge clka) disable iff (!rst_n)
                                     !$isunknown(own[r]))
      else begin
         n_fail++;
         $error("owner bits of register %0d are unknown", r);
      end
   end

   // ==============================
   // Table update
   // ==============================

   for (genvar p = 0; p < 2; p++) begin : g_port
      for (genvar b = 0; b < NB; b++) begin : g_lane
         // Lane written by this port alone
         a_claim : assert property (@(posedge clka) disable iff (!rst_n)
            wmask[p][b] && !(wmask[1-p][b] && waddr[1-p] == waddr[p])
            |=> own[$past(waddr[p])][b] == 1'(p))
         else begin
            n_fail++;
            $error("lane %0d written only by port %0d not owned by its bank", b, p);
         end
      end
   end

   for (genvar b = 0; b < NB; b++) begin : g_clash
      a_port1_wins : assert property (@(posedge clka) disable iff (!rst_n)
         wmask[0][b] && wmask[1][b] && waddr[0] == waddr[1]
         |=> own[$past(waddr[1])][b])
      else begin
         n_fail++;
         $error("lane %0d collision not won by port 1", b);
      end
   end

   // ==============================
   // Read hold
   // ==============================

   for (genvar p = 0; p < 2; p++) begin : g_hold
      a_sel_hold : assert property (@(posedge clka) disable iff (!rst_n)
                                    !rd[p].en |=> $stable(sel_q[p]))
      else begin
         n_fail++;
         $error("owner bits of read port %0d changed with en low", p);
      end
   end

endmodule

/* verilog/regfile_2w2r.sv */
`timescale 1ns/1ps

// Physical register file with two writeback lanes and two operand reads
//
// Built the live-value-table way. There is one RAM bank per write port,
// and every bank carries both read ports. A write goes only to the bank
// of its own port. The live-value table remembers which bank last wrote
// each byte of each register and picks that byte on the way out.
//
// Timing seen from outside
//   Write lands at the rising edge where wr[i].en is high
//   Read address captured at the rising edge where rd[i].en is high
//   rd_data[i] valid after that edge and held until the next enabled read
//   Same edge read and write of one register return the old entry

module regfile_2w2r #(
   parameter int DEP = regfile_pkg::PREGS     // Physical registers, at most PREGS
) (
   input  logic                  clka,
   input  logic                  rst_n,
   input  regfile_pkg::wr_port_t wr [2],      // Writeback lanes
   input  regfile_pkg::rd_req_t  rd [2],      // Operand reads
   output regfile_pkg::entry_t   rd_data [2]  // Merged read data
);

   // ==============================
   // Bank outputs
   // ==============================

   // Raw data from every bank on every read port
   // Indexed [bank][read port], the layout the table expects
   regfile_pkg::entry_t bank_dout [2][2];

   // ==============================
   // RAM banks
   // ==============================

   // Bank g takes only write lane g but serves both reads
   for (genvar g = 0; g < 2; g++) begin : g_bank
      regfile_ram #(
         .DEP  (DEP)
      ) u_bank (
         .clka (clka),
         .wr   (wr[g]),                       // Own writeback lane
         .rd   (rd),                          // Both operand reads
         .dout (bank_dout[g])                 // Registered raw data
      );
   end

   // ==============================
   // Live-value table
   // ==============================

   // Tracks newest bank per byte and merges the bank data
   regfile_live_select #(
      .DEP       (DEP)
   ) u_lvt (
      .clka      (clka),
      .rst_n     (rst_n),
      .wr        (wr),                        // Updates owner bits
      .rd        (rd),                        // Looks up owner bits
      .bank_dout (bank_dout),
      .rd_data   (rd_data)
   );

endmodule

/* verilog/regfile_live_select.sv */
`timescale 1ns/1ps

// Live-value table for the two write ports
// Each bank is written only by its own writeback lane. The table keeps,
// for every byte lane of every register, one owner bit that names the
// bank holding the newest copy of that byte. On a read the owner bits of
// the addressed register are registered alongside the bank data and the
// output word is stitched together lane by lane.

module regfile_live_select #(
   parameter int DEP = regfile_pkg::PREGS     // Registers tracked
) (
   input  logic                  clka,
   input  logic                  rst_n,
   input  regfile_pkg::wr_port_t wr [2],        // Both writeback lanes
   input  regfile_pkg::rd_req_t  rd [2],        // Both operand reads
   input  regfile_pkg::entry_t   bank_dout [2][2],  // [bank][read port]
   output regfile_pkg::entry_t   rd_data [2]    // Merged entries
);

   // ==============================
   // Local geometry
   // ==============================

   localparam int ABIT = (DEP > 1) ? $clog2(DEP) : 1;  // Decoded address bits
   localparam int NB   = regfile_pkg::NBYTE;           // Byte lanes per entry

   // ==============================
   // Table and read state
   // ==============================

   // Owner bit per lane, 0 is bank 0 and 1 is bank 1
   logic [NB-1:0]   own [DEP];

   logic [NB-1:0]   wmask [2];                // Lanes each port writes this cycle
   logic [ABIT-1:0] waddr [2];                // Decoded write addresses
   logic [ABIT-1:0] raddr [2];                // Decoded read addresses
   logic [NB-1:0]   sel_q [2];                // Owner bits captured with the read

   // ==============================
   // Port decode
   // ==============================

   for (genvar p = 0; p < 2; p++) begin : g_port
      assign wmask[p] = wr[p].en ? wr[p].be : '0;   // Qualify lanes with strobe
      assign waddr[p] = wr[p].addr[ABIT-1:0];
      assign raddr[p] = rd[p].addr[ABIT-1:0];
   end

   // ==============================
   // Table update
   // ==============================

   // Port 0 claims its lanes for bank 0 first, then port 1 claims its
   // lanes for bank 1. When both touch the same lane of the same
   // register the later nonblocking update stands, so port 1 wins.
   // Lanes not written by either port keep their owner.
   always_ff @(posedge clka or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DEP; i++) begin
            own[i] <= '0;                     // Everything lives in bank 0
         end
      end else begin
         for (int b = 0; b < NB; b++) begin
            if (wmask[0][b]) begin
               own[waddr[0]][b] <= 1'b0;      // Newest copy in bank 0
            end
            if (wmask[1][b]) begin
               own[waddr[1]][b] <= 1'b1;      // Newest copy in bank 1
            end
         end
      end
   end

   // ==============================
   // Owner lookup
   // ==============================

   // Registered at the same edge as the bank read data, and sampled
   // before the table update above, so it matches the read-first data
   always_ff @(posedge clka or negedge rst_n) begin
      if (!rst_n) begin
         sel_q[0] <= '0;
         sel_q[1] <= '0;
      end else begin
         for (int p = 0; p < 2; p++) begin
            if (rd[p].en) begin
               sel_q[p] <= own[raddr[p]];     // Hold while en is low
            end
         end
      end
   end

   // ==============================
   // Read merge
   // ==============================

   // Pure lane mux after the registers
   // Bank data and owner bits move together, so the merged word also
   // holds while the read enable stays low
   always_comb begin
      for (int p = 0; p < 2; p++) begin
         for (int b = 0; b < NB; b++) begin
            if (sel_q[p][b]) begin
               rd_data[p][b*8 +: 8] = bank_dout[1][p][b*8 +: 8];  // Bank 1 lane
            end else begin
               rd_data[p][b*8 +: 8] = bank_dout[0][p][b*8 +: 8];  // Bank 0 lane
            end
         end
      end
   end

endmodule

/* verilog/regfile_ram.sv */
`timescale 1ns/1ps

// One register bank of the file
// Simple byte-write RAM with a single write port and two read ports.
// Both read ports are registered and hold their data while their enable
// is low, the same behaviour as a block RAM in no-change mode.

module regfile_ram #(
   parameter int DEP = regfile_pkg::PREGS     // Entries in this bank
) (
   input  logic                  clka,
   input  regfile_pkg::wr_port_t wr,          // Writeback lane owned by this bank
   input  regfile_pkg::rd_req_t  rd [2],      // Operand reads from issue
   output regfile_pkg::entry_t   dout [2]     // Raw bank data per read port
);

   // ==============================
   // Local geometry
   // ==============================

   localparam int ABIT = (DEP > 1) ? $clog2(DEP) : 1;  // Bits actually decoded
   localparam int NB   = regfile_pkg::NBYTE;           // Byte lanes

   // ==============================
   // Storage
   // ==============================

   // Distributed style array with one entry per physical register
   regfile_pkg::entry_t mem [DEP];

   logic [ABIT-1:0] waddr;                    // Decoded write address
   logic [NB-1:0]   wbe;                      // Lane enables qualified by en
   logic [ABIT-1:0] raddr [2];                // Decoded read addresses

   // Power-up contents and output registers
   initial begin
      for (int n = 0; n < DEP; n++) begin
         mem[n] = '0;
      end
      dout[0] = '0;
      dout[1] = '0;
   end

   // ==============================
   // Address and enable decode
   // ==============================

   assign waddr = wr.addr[ABIT-1:0];          // Upper bits unused when DEP < PREGS
   assign wbe   = wr.en ? wr.be : '0;         // No lane written without the strobe

   for (genvar p = 0; p < 2; p++) begin : g_raddr
      assign raddr[p] = rd[p].addr[ABIT-1:0];
   end

   // ==============================
   // Write port
   // ==============================

   // Each lane lands independently
   // Lanes with a clear enable keep their old byte
   always @(posedge clka) begin
      for (int b = 0; b < NB; b++) begin
         if (wbe[b]) begin
            mem[waddr][b*8 +: 8] <= wr.data[b*8 +: 8];
         end
      end
   end

   // ==============================
   // Read ports
   // ==============================

   // The array is sampled before this edge's write updates it,
   // so a read and a write to one address see the old entry
   always @(posedge clka) begin
      for (int p = 0; p < 2; p++) begin
         if (rd[p].en) begin
            dout[p] <= mem[raddr[p]];         // One cycle latency
         end                                  // Else hold last data
      end
   end

endmodule

/* verilog/regfile_pkg.sv */
package regfile_pkg;

   // ==============================
   // Entry geometry
   // ==============================

   localparam int VWID  = 64;                 // Architectural register value
   localparam int EWID  = VWID + 8;           // Value plus one tag byte
   localparam int NBYTE = EWID / 8;           // Byte lanes per entry

   // Each lane has its own write enable, so the
   // entry must be a whole number of bytes
   localparam int TWID  = EWID - VWID;        // Tag width

   // ==============================
   // Depth and addressing
   // ==============================

   localparam int PREGS = 64;                 // Default number of physical registers
   localparam int AWID  = $clog2(PREGS);      // Address field in the port structs

   // A smaller DEP uses only the low address bits
   // of these fields, so DEP may not exceed PREGS

   // ==============================
   // Data types
   // ==============================

   typedef logic [VWID-1:0] value_t;

   // Tag in the top lane and the value below it
   // Byte lane n is bits [8n+7:8n] of the packed word
   typedef struct packed {
      logic [TWID-1:0] tag;                   // Lane NBYTE-1
      value_t          value;                 // Lanes 0 to 7
   } entry_t;

   // One writeback lane of the core
   typedef struct packed {
      logic             en;                   // Write strobe
      logic [NBYTE-1:0] be;                   // Per lane byte enables
      logic [AWID-1:0]  addr;                 // Physical register number
      entry_t           data;                 // Write data
   } wr_port_t;

   // One operand read from issue
   typedef struct packed {
      logic            en;                    // Capture address this edge
      logic [AWID-1:0] addr;                  // Physical register number
   } rd_req_t;

endpackage
